/* design/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// integer data path width
`define ALU_XLEN 64

// one-hot operation select width,
// one bit per supported operation
`define ALU_SEL_W 34

`endif

/* design/alu_pkg.sv */
`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

  // bit positions inside the one-hot operation select
  typedef enum int unsigned {
    op_add_64 = 0,  op_add_32 = 1,  op_sub = 2,      op_subw = 3,
    op_slt = 4,     op_sltu = 5,
    op_and = 6,     op_or = 7,      op_xor = 8,
    op_sll_64 = 9,  op_slli_64 = 10, op_slli_32 = 11, op_sll_32 = 12,
    op_srl_64 = 13, op_srli_64 = 14, op_srli_32 = 15, op_srl_32 = 16,
    op_sra_64 = 17, op_srai_64 = 18, op_srai_32 = 19, op_sra_32 = 20,
    op_rem_64 = 21, op_remu_64 = 22, op_remu_32 = 23, op_rem_32 = 24,
    op_div_64 = 25, op_divu_64 = 26, op_divu_32 = 27, op_div_32 = 28,
    op_mul = 29,    op_mulh = 30,    op_mulhsu = 31,  op_mulhu = 32,
    op_mul_64 = 33
  } alu_op_bit_e;

  typedef logic [`ALU_SEL_W-1:0] alu_sel_t;

  // select bits 33..29, msb first
  typedef struct packed {
    logic mul_64;
    logic mulhu;
    logic mulhsu;
    logic mulh;
    // low word, sign extended
    logic mulw;
  } mul_kind_t;

endpackage

`default_nettype wire

/* design/mul_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

interface mul_if import alu_pkg::*; ();

  // request side
  logic                 valid;
  mul_kind_t            kind;
  logic [`ALU_XLEN-1:0] multiplicand;
  logic [`ALU_XLEN-1:0] multiplier;
  logic                 ready;

  // unit side
  logic [`ALU_XLEN-1:0] product;
  logic                 stall;
  logic                 ok;

  modport requester (
    output valid, kind, multiplicand, multiplier, ready,
    input  product, stall, ok
  );

  modport unit (
    input  valid, kind, multiplicand, multiplier, ready,
    output product, stall, ok
  );

endinterface

`default_nettype wire

/* design/onehot_result_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module onehot_result_mux #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                   key,
  input  logic [DATA_LEN-1:0]                  default_out,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
  output logic [DATA_LEN-1:0]                  out
);

  // each entry is {key, data}, key in the upper bits
  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  logic [NR_KEY-1:0]   hit;
  logic [DATA_LEN-1:0] or_data;

  always_comb begin
    or_data = '0;
    for (int i = 0; i < NR_KEY; i++) begin
      hit[i]  = (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key);
      or_data = or_data | ({DATA_LEN{hit[i]}} & lut[i*PAIR_LEN +: DATA_LEN]);
    end
  end

  // nothing matched, fall back to default
  assign out = (|hit) ? or_data : default_out;

  // table keys must be distinct
  always_comb begin
    assert ($onehot0(hit))
      else $error("onehot_result_mux: more than one lut entry matches key %h", key);
  end

endmodule

`default_nettype wire

/* design/mul_seq_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module mul_seq_unit import alu_pkg::*; (
  input logic clk,
  input logic arst_n,
  mul_if.unit mul
);

  localparam int XLEN  = `ALU_XLEN;
  localparam int CNT_W = $clog2(XLEN);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_fin,
    st_done
  } state_e;

  state_e            state;
  logic [CNT_W-1:0]  step_cnt;
  mul_kind_t         kind_q;
  logic              neg_q;
  logic [XLEN-1:0]   mcand_q;
  logic [2*XLEN-1:0] acc_q;
  logic [XLEN-1:0]   product_q;

  logic              a_signed;
  logic              b_signed;
  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [XLEN:0]     step_sum;
  logic [2*XLEN-1:0] full;
  logic              start;

  // mulh signs both operands and mulhsu only the multiplicand
  assign a_signed = mul.kind.mulh | mul.kind.mulhsu;
  assign b_signed = mul.kind.mulh;
  assign a_neg    = a_signed & mul.multiplicand[XLEN-1];
  assign b_neg    = b_signed & mul.multiplier[XLEN-1];
  assign a_mag    = a_neg ? (~mul.multiplicand + 1'b1) : mul.multiplicand;
  assign b_mag    = b_neg ? (~mul.multiplier + 1'b1) : mul.multiplier;

  assign start = (state == st_idle) && mul.valid;

  // upper half plus multiplicand with its carry
  assign step_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, mcand_q};
  assign full     = neg_q ? (~acc_q + 1'b1) : acc_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (mul.valid) begin
            state    <= st_run;
            step_cnt <= '0;
          end
        end
        st_run: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == CNT_W'(XLEN - 1)) begin
            state <= st_fin;
          end
        end
        st_fin: state <= st_done;
        // hold until the load/store stage takes it
        st_done: begin
          if (mul.ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      kind_q  <= mul.kind;
      neg_q   <= a_neg ^ b_neg;
      mcand_q <= a_mag;
      acc_q   <= {{XLEN{1'b0}}, b_mag};
    end else if (state == st_run) begin
      // lsb of the multiplier decides add or plain shift
      if (acc_q[0]) begin
        acc_q <= {step_sum, acc_q[XLEN-1:1]};
      end else begin
        acc_q <= {1'b0, acc_q[2*XLEN-1:1]};
      end
    end
    if (state == st_fin) begin
      if (kind_q.mulw) begin
        product_q <= {{(XLEN/2){full[XLEN/2-1]}}, full[XLEN/2-1:0]};
      end else if (kind_q.mul_64) begin
        product_q <= full[XLEN-1:0];
      end else begin
        product_q <= full[2*XLEN-1:XLEN];
      end
    end
  end

  assign mul.product = product_q;
  assign mul.stall   = (state != st_idle);
  assign mul.ok      = (state == st_done);

  // back-pressure freezes the finished result
  a_hold_under_backpressure: assert property (@(posedge clk) disable iff (!arst_n)
    (mul.ok && !mul.ready) |=> (mul.ok && mul.stall && $stable(mul.product)))
    else $error("mul_seq_unit: result not held under back-pressure");

  a_kind_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    (state == st_run) |-> $onehot(kind_q))
    else $error("mul_seq_unit: captured kind %b not one-hot", kind_q);

endmodule

`default_nettype wire

/* design/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_core import alu_pkg::*; (
  input  logic [`ALU_XLEN-1:0] op_1,
  input  logic [`ALU_XLEN-1:0] op_2,
  input  alu_sel_t             alu_sel,
  input  logic                 lsu_stall,
  mul_if.requester             mul,
  output logic [`ALU_XLEN-1:0] result
);

  localparam int XLEN   = `ALU_XLEN;
  localparam int SEL_W  = `ALU_SEL_W;
  localparam int PAIR_W = SEL_W + XLEN;

  function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  logic            op_suber;
  logic [XLEN-1:0] op_2_in;
  logic [XLEN-1:0] sum;
  logic            slt_bit;
  logic            sltu_bit;

  logic            shift_64;
  logic            right_32;
  logic            arith_32;
  logic [5:0]      shamt;
  logic [XLEN-1:0] usrc;
  logic [XLEN-1:0] ssrc;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;

  logic [XLEN-1:0] div_s;
  logic [XLEN-1:0] div_u;
  logic [XLEN-1:0] rem_s;
  logic [XLEN-1:0] rem_u;
  logic [31:0]     divw_s;
  logic [31:0]     divw_u;
  logic [31:0]     remw_s;
  logic [31:0]     remw_u;

  logic [XLEN-1:0]         res_by_op [SEL_W];
  logic [SEL_W*PAIR_W-1:0] lut;

  // sub, subw and both compares reuse the adder
  assign op_suber = alu_sel[op_sub] | alu_sel[op_subw] | alu_sel[op_slt] | alu_sel[op_sltu];
  assign op_2_in  = op_suber ? (~op_2 + 1'b1) : op_2;
  assign sum      = op_1 + op_2_in;

  // sign bits differ, else look at the difference
  assign slt_bit  = (op_1[XLEN-1] & ~op_2[XLEN-1]) |
                    ((op_1[XLEN-1] == op_2[XLEN-1]) & sum[XLEN-1]);
  assign sltu_bit = (~op_1[XLEN-1] & op_2[XLEN-1]) |
                    ((op_1[XLEN-1] == op_2[XLEN-1]) & sum[XLEN-1]);

  // 64-bit forms take six bits of shift amount
  assign shift_64 = alu_sel[op_sll_64] | alu_sel[op_slli_64] |
                    alu_sel[op_srl_64] | alu_sel[op_srli_64] |
                    alu_sel[op_sra_64] | alu_sel[op_srai_64];
  assign shamt    = {shift_64 & op_2[5], op_2[4:0]};

  // word right shifts see only the low word, filled first
  assign right_32 = alu_sel[op_srli_32] | alu_sel[op_srl_32];
  assign arith_32 = alu_sel[op_srai_32] | alu_sel[op_sra_32];
  assign usrc     = right_32 ? {{(XLEN-32){1'b0}}, op_1[31:0]} : op_1;
  assign ssrc     = arith_32 ? sext32(op_1[31:0]) : op_1;

  assign sll_res = op_1 << shamt;
  assign srl_res = usrc >> shamt;
  assign sra_res = $signed(ssrc) >>> shamt;

  // divisor assumed nonzero
  assign div_s  = $signed(op_1) / $signed(op_2);
  assign div_u  = op_1 / op_2;
  assign rem_s  = $signed(op_1) % $signed(op_2);
  assign rem_u  = op_1 % op_2;
  assign divw_s = $signed(op_1[31:0]) / $signed(op_2[31:0]);
  assign divw_u = op_1[31:0] / op_2[31:0];
  assign remw_s = $signed(op_1[31:0]) % $signed(op_2[31:0]);
  assign remw_u = op_1[31:0] % op_2[31:0];

  // multiply request, product comes back through the same bus
  assign mul.valid        = |alu_sel[op_mul_64:op_mul];
  assign mul.kind         = mul_kind_t'(alu_sel[op_mul_64:op_mul]);
  assign mul.multiplicand = op_1;
  assign mul.multiplier   = op_2;
  assign mul.ready        = ~lsu_stall;

  always_comb begin
    res_by_op[op_add_64]  = sum;
    res_by_op[op_add_32]  = sext32(sum[31:0]);
    res_by_op[op_sub]     = sum;
    res_by_op[op_subw]    = sext32(sum[31:0]);
    res_by_op[op_slt]     = {{(XLEN-1){1'b0}}, slt_bit};
    res_by_op[op_sltu]    = {{(XLEN-1){1'b0}}, sltu_bit};
    res_by_op[op_and]     = op_1 & op_2;
    res_by_op[op_or]      = op_1 | op_2;
    res_by_op[op_xor]     = op_1 ^ op_2;
    res_by_op[op_sll_64]  = sll_res;
    res_by_op[op_slli_64] = sll_res;
    res_by_op[op_slli_32] = sext32(sll_res[31:0]);
    res_by_op[op_sll_32]  = sext32(sll_res[31:0]);
    res_by_op[op_srl_64]  = srl_res;
    res_by_op[op_srli_64] = srl_res;
    res_by_op[op_srli_32] = sext32(srl_res[31:0]);
    res_by_op[op_srl_32]  = sext32(srl_res[31:0]);
    res_by_op[op_sra_64]  = sra_res;
    res_by_op[op_srai_64] = sra_res;
    res_by_op[op_srai_32] = sext32(sra_res[31:0]);
    res_by_op[op_sra_32]  = sext32(sra_res[31:0]);
    res_by_op[op_rem_64]  = rem_s;
    res_by_op[op_remu_64] = rem_u;
    res_by_op[op_remu_32] = sext32(remw_u);
    res_by_op[op_rem_32]  = sext32(remw_s);
    res_by_op[op_div_64]  = div_s;
    res_by_op[op_divu_64] = div_u;
    res_by_op[op_divu_32] = sext32(divw_u);
    res_by_op[op_div_32]  = sext32(divw_s);
    // every multiply form returns the unit's product
    res_by_op[op_mul]     = mul.product;
    res_by_op[op_mulh]    = mul.product;
    res_by_op[op_mulhsu]  = mul.product;
    res_by_op[op_mulhu]   = mul.product;
    res_by_op[op_mul_64]  = mul.product;
  end

  // key of entry i is the single select bit i
  always_comb begin
    for (int i = 0; i < SEL_W; i++) begin
      lut[i*PAIR_W +: PAIR_W] = {alu_sel_t'(1) << i, res_by_op[i]};
    end
  end

  onehot_result_mux #(
    .NR_KEY   (SEL_W),
    .KEY_LEN  (SEL_W),
    .DATA_LEN (XLEN)
  ) result_mux_inst (
    .key         (alu_sel),
    .default_out ({XLEN{1'b0}}),
    .lut         (lut),
    .out         (result)
  );

  always_comb begin
    assert ($onehot0(alu_sel))
      else $error("alu_core: alu_sel %h selects more than one operation", alu_sel);
  end

endmodule

`default_nettype wire

/* design/alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_top import alu_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [`ALU_XLEN-1:0] op_1,
  input  logic [`ALU_XLEN-1:0] op_2,
  input  alu_sel_t             alu_sel,
  input  logic                 lsu_stall,
  output logic [`ALU_XLEN-1:0] result,
  output logic                 alu_stall,
  output logic                 alu_ok
);

  // core to multiplier handshake
  mul_if mul_bus ();

  alu_core alu_core_inst (
    .op_1      (op_1),
    .op_2      (op_2),
    .alu_sel   (alu_sel),
    .lsu_stall (lsu_stall),
    .mul       (mul_bus.requester),
    .result    (result)
  );

  mul_seq_unit mul_seq_unit_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .mul    (mul_bus.unit)
  );

  assign alu_stall = mul_bus.stall;
  assign alu_ok    = mul_bus.ok;

endmodule

`default_nettype wire

/* verification/alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_tb import alu_pkg::*; ();

  localparam int XLEN         = `ALU_XLEN;
  localparam int RAND_N       = 6;
  localparam int N_ARITH_EDGE = 5;
  localparam int N_SHAMT      = 6;
  localparam int N_DIV_EDGE   = 4;
  // one per applied operation, reset check and back-pressure run included
  localparam int NUM_TESTS = 1 + 6 * (N_ARITH_EDGE + RAND_N) + 3 * RAND_N +
                             12 * (N_SHAMT + RAND_N) + 8 * (N_DIV_EDGE + RAND_N) + 5 * 2 + 1;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 80 + 200;

  logic            clk;
  logic            arst_n;
  logic [XLEN-1:0] op_1;
  logic [XLEN-1:0] op_2;
  alu_sel_t        alu_sel;
  logic            lsu_stall;
  logic [XLEN-1:0] result;
  logic            alu_stall;
  logic            alu_ok;
  integer          seed = 32'h4ef2;

  alu_top alu_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_1      (op_1),
    .op_2      (op_2),
    .alu_sel   (alu_sel),
    .lsu_stall (lsu_stall),
    .result    (result),
    .alu_stall (alu_stall),
    .alu_ok    (alu_ok)
  );

  // 20 ns period
  always #10 clk = ~clk;

  function automatic logic [XLEN-1:0] word_sext(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // RV64IM semantics, divisor never zero
  function automatic logic [XLEN-1:0] ref_op(input alu_op_bit_e op, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ss;
    logic [2*XLEN-1:0] su;
    logic [2*XLEN-1:0] uu;
    ss = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
    su = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
    uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      op_add_64:              return a + b;
      op_add_32:              return word_sext(a[31:0] + b[31:0]);
      op_sub:                 return a - b;
      op_subw:                return word_sext(a[31:0] - b[31:0]);
      op_slt:                 return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      op_sltu:                return (a < b) ? 64'd1 : 64'd0;
      op_and:                 return a & b;
      op_or:                  return a | b;
      op_xor:                 return a ^ b;
      op_sll_64, op_slli_64:  return a << b[5:0];
      op_sll_32, op_slli_32:  return word_sext(a[31:0] << b[4:0]);
      op_srl_64, op_srli_64:  return a >> b[5:0];
      op_srl_32, op_srli_32:  return word_sext(a[31:0] >> b[4:0]);
      op_sra_64, op_srai_64:  return $signed(a) >>> b[5:0];
      op_sra_32, op_srai_32:  return word_sext($signed(a[31:0]) >>> b[4:0]);
      op_rem_64:              return $signed(a) % $signed(b);
      op_remu_64:             return a % b;
      op_rem_32:              return word_sext($signed(a[31:0]) % $signed(b[31:0]));
      op_remu_32:             return word_sext(a[31:0] % b[31:0]);
      op_div_64:              return $signed(a) / $signed(b);
      op_divu_64:             return a / b;
      op_div_32:              return word_sext($signed(a[31:0]) / $signed(b[31:0]));
      op_divu_32:             return word_sext(a[31:0] / b[31:0]);
      // mulw keeps the low word
      op_mul:                 return word_sext(uu[31:0]);
      op_mulh:                return ss[2*XLEN-1:XLEN];
      op_mulhsu:              return su[2*XLEN-1:XLEN];
      op_mulhu:               return uu[2*XLEN-1:XLEN];
      op_mul_64:              return uu[XLEN-1:0];
      default:                return '0;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, msg, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // drive 2 ns after the edge, look at the result mid-cycle
  task automatic check_comb(input alu_op_bit_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
    string tag;
    @(posedge clk);
    #2;
    alu_sel = alu_sel_t'(1) << op;
    op_1    = a;
    op_2    = b;
    #5;
    tag = $sformatf("%s a=%h b=%h", op.name(), a, b);
    check_eq(result, ref_op(op, a, b), tag);
    check_eq(alu_ok, '0, {tag, " alu_ok"});
  endtask

  task automatic run_ops(input int first, input int last, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
    for (int k = first; k <= last; k++) begin
      check_comb(alu_op_bit_e'(k), a, b);
    end
  endtask

  // hold > 0 keeps lsu_stall high for that many cycles after alu_ok
  task automatic run_mul(input alu_op_bit_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input int hold);
    int              waited;
    logic [XLEN-1:0] exp;
    string           tag;
    waited = 0;
    exp    = ref_op(op, a, b);
    tag    = $sformatf("%s a=%h b=%h", op.name(), a, b);
    @(posedge clk);
    #2;
    alu_sel   = alu_sel_t'(1) << op;
    op_1      = a;
    op_2      = b;
    lsu_stall = (hold > 0);
    @(posedge clk);
    #1;
    check_eq(alu_stall, 1, {tag, " alu_stall after capture"});
    while (alu_ok !== 1'b1) begin
      if (waited >= 70) begin
        abort_run({"multiply never finished, no alu_ok within 70 cycles for ", tag});
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
    check_eq(result, exp, tag);
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_eq(alu_ok, 1, {tag, " alu_ok under back-pressure"});
      check_eq(alu_stall, 1, {tag, " alu_stall under back-pressure"});
      check_eq(result, exp, {tag, " held result"});
    end
    #1;
    lsu_stall = 1'b0;
    @(posedge clk);
    #1;
    check_eq(alu_ok, 0, {tag, " alu_ok after handshake"});
    check_eq(alu_stall, 0, {tag, " alu_stall after handshake"});
    #1;
    alu_sel = '0;
  endtask

  task automatic test_reset_state();
    @(posedge clk);
    #1;
    check_eq(alu_stall, 0, "alu_stall after reset");
    check_eq(alu_ok, 0, "alu_ok after reset");
    check_eq(result, 0, "result with zero select");
  endtask

  task automatic test_arith();
    logic [XLEN-1:0] edge_a [N_ARITH_EDGE];
    logic [XLEN-1:0] edge_b [N_ARITH_EDGE];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    edge_a = '{64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'h1234_5678_9abc_def0,
               64'h0, 64'h0000_0000_ffff_ffff};
    edge_b = '{64'h1, 64'h7fff_ffff_ffff_ffff, 64'h1234_5678_9abc_def0,
               64'h8000_0000_0000_0000, 64'h1};
    for (int i = 0; i < N_ARITH_EDGE; i++) begin
      run_ops(op_add_64, op_sltu, edge_a[i], edge_b[i]);
    end
    repeat (RAND_N) begin
      a = rand64();
      b = rand64();
      run_ops(op_add_64, op_sltu, a, b);
    end
  endtask

  task automatic test_logic_shift();
    int              amts [N_SHAMT];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    amts = '{0, 1, 31, 32, 33, 63};
    repeat (RAND_N) begin
      a = rand64();
      b = rand64();
      run_ops(op_and, op_xor, a, b);
    end
    for (int i = 0; i < N_SHAMT + RAND_N; i++) begin
      a = rand64();
      b = rand64();
      if (i < N_SHAMT) begin
        b[5:0] = amts[i][5:0];
        // both fills for the word right shifts
        a[31]  = i[0];
      end
      run_ops(op_sll_64, op_sra_32, a, b);
    end
  endtask

  task automatic test_div_rem();
    logic [XLEN-1:0] edge_a [N_DIV_EDGE];
    logic [XLEN-1:0] edge_b [N_DIV_EDGE];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    edge_a = '{-64'sd20, 64'd20, -64'sd20, 64'hffff_fff0_8000_0005};
    edge_b = '{64'd3, -64'sd3, -64'sd3, 64'h0000_0000_ffff_fff9};
    for (int i = 0; i < N_DIV_EDGE; i++) begin
      run_ops(op_rem_64, op_div_32, edge_a[i], edge_b[i]);
    end
    repeat (RAND_N) begin
      a = rand64();
      // odd divisor, nonzero in both widths
      b = rand64() | 64'h1;
      run_ops(op_rem_64, op_div_32, a, b);
    end
  endtask

  task automatic test_mul_forms();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int k = op_mul; k <= op_mul_64; k++) begin
      a = rand64();
      b = rand64();
      run_mul(alu_op_bit_e'(k), a, b, 0);
      run_mul(alu_op_bit_e'(k), 64'hffff_ffff_ffff_fff9, 64'h0000_0001_2345_6789, 0);
    end
  endtask

  task automatic test_backpressure();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = rand64();
    b = rand64();
    run_mul(op_mulhsu, a, b, 10);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    op_1      = '0;
    op_2      = '0;
    alu_sel   = '0;
    lsu_stall = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    test_reset_state();
    test_arith();
    test_logic_shift();
    test_div_rem();
    test_mul_forms();
    test_backpressure();
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/alu_pkg.sv
design/mul_if.sv
design/onehot_result_mux.sv
design/mul_seq_unit.sv
design/alu_core.sv
design/alu_top.sv
verification/alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f filelist.f \
  -o alu_sim > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/alu_sim > sim.log 2>&1 || echo "simulator exited with a nonzero status"
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
